/* verilog/datapath_config.svh */
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// Datapath and register file sizes
`define DATA_WIDTH      16
`define REG_ADDR_WIDTH  4
`define REG_COUNT       16

// Clock cycles per instruction, small for simulation
`define STEP_TICKS      4

// Clock cycles each display digit stays lit
`define SCAN_TICKS      2

// Wishbone address map, addresses 0 to 15 read the registers
`define WB_ADDR_WIDTH   5
`define ADDR_CONTROL    16
`define ADDR_SEED_A     17
`define ADDR_SEED_B     18

`endif

/* verilog/datapath_pkg.sv */
`default_nettype none

package datapath_pkg;

	// ALU operations used by the Fibonacci program
	typedef enum logic
	{
		ALU_LOAD = 1'b0,
		ALU_ADD  = 1'b1
	} aluOpT;

	// Bit positions in the 5-bit flag vector
	localparam int FLAG_CARRY    = 0;
	localparam int FLAG_ZERO     = 1;
	localparam int FLAG_NEGATIVE = 2;
	localparam int FLAG_OVERFLOW = 3;
	localparam int FLAG_LOWER    = 4;

endpackage

`default_nettype wire

/* verilog/RegisterFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_config.svh"

module RegisterFile
(
	input  logic                        Clk,
	input  logic                        RESET,
	input  logic [`REG_ADDR_WIDTH-1:0]  ReadAddrA,
	input  logic [`REG_ADDR_WIDTH-1:0]  ReadAddrB,
	input  logic [`REG_ADDR_WIDTH-1:0]  WriteAddr,
	input  logic [`REG_ADDR_WIDTH-1:0]  HostAddr,
	input  logic                        WriteEnable,
	input  logic [`DATA_WIDTH-1:0]      WriteData,
	output logic [`DATA_WIDTH-1:0]      ReadDataA,
	output logic [`DATA_WIDTH-1:0]      ReadDataB,
	output logic [`DATA_WIDTH-1:0]      HostData
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (WriteEnable)
		begin
			regs[WriteAddr] <= WriteData;
		end
	end

	// Operand ports for the ALU and a third port for the host bus
	assign ReadDataA = regs[ReadAddrA];
	assign ReadDataB = regs[ReadAddrB];
	assign HostData  = regs[HostAddr];

	// Sequencer must present a valid index on every write
	writeAddrKnown: assert property (@(posedge Clk) disable iff (RESET)
		WriteEnable |-> !$isunknown(WriteAddr));

endmodule

`default_nettype wire

/* verilog/Alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_config.svh"

module Alu
	import datapath_pkg::*;
(
	input  aluOpT                   Op,
	input  logic [`DATA_WIDTH-1:0]  A,
	input  logic [`DATA_WIDTH-1:0]  B,
	input  logic [`DATA_WIDTH-1:0]  Immediate,
	output logic [`DATA_WIDTH-1:0]  Result,
	output logic [4:0]              Flags
);

	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	logic [`DATA_WIDTH:0]   sum;

	// A load behaves as zero plus the immediate, so flags follow one rule
	always_comb
	begin
		if (Op == ALU_ADD)
		begin
			opA = A;
			opB = B;
		end
		else
		begin
			opA = '0;
			opB = Immediate;
		end
	end

	// Carry-in is tied to zero
	assign sum    = {1'b0, opA} + {1'b0, opB};
	assign Result = sum[`DATA_WIDTH-1:0];

	always_comb
	begin
		Flags                = '0;
		Flags[FLAG_CARRY]    = sum[`DATA_WIDTH];
		Flags[FLAG_ZERO]     = (Result == '0);
		Flags[FLAG_NEGATIVE] = Result[`DATA_WIDTH-1];
		// Signed overflow when both operands agree in sign and the result does not
		Flags[FLAG_OVERFLOW] = (opA[`DATA_WIDTH-1] == opB[`DATA_WIDTH-1]) &&
			(Result[`DATA_WIDTH-1] != opA[`DATA_WIDTH-1]);
		Flags[FLAG_LOWER]    = (opA < opB);
	end

endmodule

`default_nettype wire

/* verilog/ProgramSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_config.svh"

module ProgramSequencer
	import datapath_pkg::*;
(
	input  logic                        Clk,
	input  logic                        RESET,
	input  logic                        Start,
	input  logic [`DATA_WIDTH-1:0]      SeedA,
	input  logic [`DATA_WIDTH-1:0]      SeedB,
	output logic                        Busy,
	output logic                        WriteEnable,
	output logic [`REG_ADDR_WIDTH-1:0]  ReadAddrA,
	output logic [`REG_ADDR_WIDTH-1:0]  ReadAddrB,
	output logic [`REG_ADDR_WIDTH-1:0]  WriteAddr,
	output aluOpT                       Op,
	output logic [`DATA_WIDTH-1:0]      Immediate
);

	localparam int TickWidth = $clog2(`STEP_TICKS);
	localparam logic [TickWidth-1:0] LastTick = TickWidth'(`STEP_TICKS - 1);
	localparam logic [`REG_ADDR_WIDTH-1:0] LastStep = `REG_ADDR_WIDTH'(`REG_COUNT - 1);

	typedef enum logic [1:0]
	{
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_DONE
	} seqStateT;

	seqStateT                    state;
	logic [TickWidth-1:0]        tickCount;
	logic [`REG_ADDR_WIDTH-1:0]  stepIndex;

	////////////////////////////////////////////////////////////////////////////
	// Step pacing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			state     <= SEQ_IDLE;
			tickCount <= '0;
			stepIndex <= '0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
				begin
					if (Start)
					begin
						state     <= SEQ_RUN;
						tickCount <= '0;
						stepIndex <= '0;
					end
				end
				SEQ_RUN:
				begin
					if (tickCount == LastTick)
					begin
						tickCount <= '0;
						if (stepIndex == LastStep)
							state <= SEQ_DONE;
						else
							stepIndex <= stepIndex + 1'b1;
					end
					else
					begin
						tickCount <= tickCount + 1'b1;
					end
				end
				// One trailing busy cycle after r15 lands
				default:
					state <= SEQ_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction decode
	////////////////////////////////////////////////////////////////////////////

	assign Busy        = (state != SEQ_IDLE);
	assign WriteEnable = (state == SEQ_RUN) && (tickCount == LastTick);

	// Step k adds r(k-2) and r(k-1) into rk, steps 0 and 1 load the seeds
	assign WriteAddr = stepIndex;
	assign ReadAddrA = stepIndex - 2'd2;
	assign ReadAddrB = stepIndex - 2'd1;
	assign Op        = (stepIndex < 2) ? ALU_LOAD : ALU_ADD;
	assign Immediate = (stepIndex == '0) ? SeedA : SeedB;

	// A write ends a full step interval, never the first busy cycle
	writeAfterBusy: assert property (@(posedge Clk) disable iff (RESET)
		$rose(WriteEnable) |-> $past(Busy));

	// A second start during a run must not restart the program
	startIgnoredWhileBusy: assert property (@(posedge Clk) disable iff (RESET)
		(Start && Busy && !WriteEnable) |=> $stable(stepIndex));

endmodule

`default_nettype wire

/* verilog/HostBusPort.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_config.svh"

module HostBusPort
(
	input  logic                        Clk,
	input  logic                        RESET,
	input  logic                        WbCyc,
	input  logic                        WbStb,
	input  logic                        WbWe,
	input  logic [`WB_ADDR_WIDTH-1:0]   WbAdr,
	input  logic [`DATA_WIDTH-1:0]      WbDatWrite,
	input  logic                        Busy,
	input  logic [4:0]                  LastFlags,
	input  logic [`DATA_WIDTH-1:0]      HostData,
	output logic                        WbAck,
	output logic [`DATA_WIDTH-1:0]      WbDatRead,
	output logic                        Start,
	output logic [`DATA_WIDTH-1:0]      SeedA,
	output logic [`DATA_WIDTH-1:0]      SeedB,
	output logic [`REG_ADDR_WIDTH-1:0]  HostAddr
);

	localparam logic [`WB_ADDR_WIDTH-1:0] AddrControl = `ADDR_CONTROL;
	localparam logic [`WB_ADDR_WIDTH-1:0] AddrSeedA   = `ADDR_SEED_A;
	localparam logic [`WB_ADDR_WIDTH-1:0] AddrSeedB   = `ADDR_SEED_B;

	logic                    request;
	logic                    writeStrobe;
	logic [`DATA_WIDTH-1:0]  readMux;

	// New request only while no acknowledge is pending
	assign request     = WbCyc && WbStb && !WbAck;
	assign writeStrobe = WbAck && WbCyc && WbStb && WbWe;

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			WbAck <= 1'b0;
			SeedA <= '0;
			SeedB <= '0;
		end
		else
		begin
			WbAck <= request;
			if (writeStrobe && WbAdr == AddrSeedA)
				SeedA <= WbDatWrite;
			if (writeStrobe && WbAdr == AddrSeedB)
				SeedB <= WbDatWrite;
		end
	end

	// Start is dropped when a run is already in progress
	assign Start = writeStrobe && (WbAdr == AddrControl) && WbDatWrite[0] && !Busy;

	assign HostAddr = WbAdr[`REG_ADDR_WIDTH-1:0];

	always_comb
	begin
		readMux = '0;
		if (WbAdr < `REG_COUNT)
			readMux = HostData;
		else if (WbAdr == AddrControl)
			readMux = {{(`DATA_WIDTH - 6){1'b0}}, LastFlags, Busy};
		else if (WbAdr == AddrSeedA)
			readMux = SeedA;
		else if (WbAdr == AddrSeedB)
			readMux = SeedB;
	end

	// Read data captured with the acknowledge
	always_ff @(posedge Clk)
	begin
		if (request)
			WbDatRead <= readMux;
	end

	ackSingleCycle: assert property (@(posedge Clk) disable iff (RESET)
		WbAck |=> !WbAck);

endmodule

`default_nettype wire

/* verilog/SevenSegmentScanner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_config.svh"

module SevenSegmentScanner
	import datapath_pkg::*;
(
	input  logic                    Clk,
	input  logic                    RESET,
	input  logic                    Capture,
	input  logic [`DATA_WIDTH-1:0]  Value,
	input  logic [4:0]              FlagsIn,
	output logic [6:0]              SevenSegment,
	output logic [3:0]              Enable,
	output logic [3:0]              Led,
	output logic [4:0]              LastFlags
);

	localparam int ScanWidth = $clog2(`SCAN_TICKS);
	localparam logic [ScanWidth-1:0] LastScan = ScanWidth'(`SCAN_TICKS - 1);

	logic [`DATA_WIDTH-1:0]  shownValue;
	logic [ScanWidth-1:0]    scanCount;
	logic [1:0]              digitIndex;
	logic [3:0]              nibble;

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			shownValue <= '0;
			LastFlags  <= '0;
			scanCount  <= '0;
			digitIndex <= '0;
		end
		else
		begin
			if (Capture)
			begin
				shownValue <= Value;
				LastFlags  <= FlagsIn;
			end
			if (scanCount == LastScan)
			begin
				scanCount  <= '0;
				digitIndex <= digitIndex + 1'b1;
			end
			else
			begin
				scanCount <= scanCount + 1'b1;
			end
		end
	end

	assign nibble = shownValue[digitIndex*4 +: 4];
	// One active-low enable per digit
	assign Enable = ~(4'b0001 << digitIndex);

	assign Led = {LastFlags[FLAG_OVERFLOW], LastFlags[FLAG_NEGATIVE],
		LastFlags[FLAG_ZERO], LastFlags[FLAG_CARRY]};

	// Active-low glyphs, bit 0 is segment a
	always_comb
	begin
		case (nibble)
			4'h0: SevenSegment = 7'h40;
			4'h1: SevenSegment = 7'h79;
			4'h2: SevenSegment = 7'h24;
			4'h3: SevenSegment = 7'h30;
			4'h4: SevenSegment = 7'h19;
			4'h5: SevenSegment = 7'h12;
			4'h6: SevenSegment = 7'h02;
			4'h7: SevenSegment = 7'h78;
			4'h8: SevenSegment = 7'h00;
			4'h9: SevenSegment = 7'h10;
			4'hA: SevenSegment = 7'h08;
			4'hB: SevenSegment = 7'h03;
			4'hC: SevenSegment = 7'h46;
			4'hD: SevenSegment = 7'h21;
			4'hE: SevenSegment = 7'h06;
			default: SevenSegment = 7'h0E;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/FibonacciDatapathTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_config.svh"

module FibonacciDatapathTop
	import datapath_pkg::*;
(
	input  logic                       Clk,
	input  logic                       RESET,
	input  logic                       WbCyc,
	input  logic                       WbStb,
	input  logic                       WbWe,
	input  logic [`WB_ADDR_WIDTH-1:0]  WbAdr,
	input  logic [`DATA_WIDTH-1:0]     WbDatWrite,
	output logic                       WbAck,
	output logic [`DATA_WIDTH-1:0]     WbDatRead,
	output logic [6:0]                 SevenSegment,
	output logic [3:0]                 Enable,
	output logic [3:0]                 Led
);

	logic                        busy;
	logic                        writeEnable;
	logic                        start;
	logic [`REG_ADDR_WIDTH-1:0]  readAddrA;
	logic [`REG_ADDR_WIDTH-1:0]  readAddrB;
	logic [`REG_ADDR_WIDTH-1:0]  writeAddr;
	logic [`REG_ADDR_WIDTH-1:0]  hostAddr;
	logic [`DATA_WIDTH-1:0]      readDataA;
	logic [`DATA_WIDTH-1:0]      readDataB;
	logic [`DATA_WIDTH-1:0]      hostData;
	logic [`DATA_WIDTH-1:0]      result;
	logic [`DATA_WIDTH-1:0]      immediate;
	logic [`DATA_WIDTH-1:0]      seedA;
	logic [`DATA_WIDTH-1:0]      seedB;
	logic [4:0]                  flags;
	logic [4:0]                  lastFlags;
	aluOpT                       op;

	RegisterFile RegisterFile_inst (.Clk(Clk), .RESET(RESET), .ReadAddrA(readAddrA),
		.ReadAddrB(readAddrB), .WriteAddr(writeAddr), .HostAddr(hostAddr),
		.WriteEnable(writeEnable), .WriteData(result), .ReadDataA(readDataA),
		.ReadDataB(readDataB), .HostData(hostData));

	Alu Alu_inst (.Op(op), .A(readDataA), .B(readDataB), .Immediate(immediate),
		.Result(result), .Flags(flags));

	ProgramSequencer ProgramSequencer_inst (.Clk(Clk), .RESET(RESET), .Start(start),
		.SeedA(seedA), .SeedB(seedB), .Busy(busy), .WriteEnable(writeEnable),
		.ReadAddrA(readAddrA), .ReadAddrB(readAddrB), .WriteAddr(writeAddr),
		.Op(op), .Immediate(immediate));

	HostBusPort HostBusPort_inst (.Clk(Clk), .RESET(RESET), .WbCyc(WbCyc), .WbStb(WbStb),
		.WbWe(WbWe), .WbAdr(WbAdr), .WbDatWrite(WbDatWrite), .Busy(busy),
		.LastFlags(lastFlags), .HostData(hostData), .WbAck(WbAck), .WbDatRead(WbDatRead),
		.Start(start), .SeedA(seedA), .SeedB(seedB), .HostAddr(hostAddr));

	// Display follows each register write
	SevenSegmentScanner SevenSegmentScanner_inst (.Clk(Clk), .RESET(RESET),
		.Capture(writeEnable), .Value(result), .FlagsIn(flags),
		.SevenSegment(SevenSegment), .Enable(Enable), .Led(Led), .LastFlags(lastFlags));

endmodule

`default_nettype wire

/* tests/FibonacciDatapathTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_config.svh"

module FibonacciDatapathTb
	import datapath_pkg::*;
();

	localparam int NumRuns      = 6;
	localparam int AckLimit     = 4;
	localparam int AccessCycles = 3;
	localparam int RunCycles    = `REG_COUNT * `STEP_TICKS + 1;
	// Seeds, start, mid-run accesses, busy polls, register reads and the display scan
	localparam int PerRunCycles = RunCycles + AccessCycles * (RunCycles / AccessCycles + 28)
		+ 8 * `SCAN_TICKS;
	localparam int TimeoutCycles = NumRuns * PerRunCycles + AccessCycles * 40 + 200;

	logic                       Clk;
	logic                       RESET;
	logic                       WbCyc;
	logic                       WbStb;
	logic                       WbWe;
	logic [`WB_ADDR_WIDTH-1:0]  WbAdr;
	logic [`DATA_WIDTH-1:0]     WbDatWrite;
	logic                       WbAck;
	logic [`DATA_WIDTH-1:0]     WbDatRead;
	logic [6:0]                 SevenSegment;
	logic [3:0]                 Enable;
	logic [3:0]                 Led;

	integer                  randomSeed;
	int                      cycleCount;
	logic [`DATA_WIDTH-1:0]  model [`REG_COUNT];
	logic [`DATA_WIDTH-1:0]  readValue;
	logic [4:0]              expectedFlags;
	logic [3:0]              seenDigits;
	int                      lowCount;
	int                      digit;

	FibonacciDatapathTop FibonacciDatapathTop_inst (.Clk(Clk), .RESET(RESET), .WbCyc(WbCyc),
		.WbStb(WbStb), .WbWe(WbWe), .WbAdr(WbAdr), .WbDatWrite(WbDatWrite), .WbAck(WbAck),
		.WbDatRead(WbDatRead), .SevenSegment(SevenSegment), .Enable(Enable), .Led(Led));

	initial
	begin
		Clk = 1'b0;
	end

	always #4 Clk = ~Clk;

	////////////////////////////////////////////////////////////////////////////
	// Failure handling and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			abortRun($sformatf("[ERROR] %s expected %h actual %h", testName, expected, actual));
	endtask

	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
			abortRun("Simulation ran past its cycle limit without finishing the tests");
	end

	////////////////////////////////////////////////////////////////////////////
	// Wishbone classic master, entered and left on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic busTransfer(input logic write, input int addr, input logic [15:0] wdata,
		output logic [15:0] rdata);
		logic ackSeen;
		ackSeen    = 1'b0;
		WbCyc      = 1'b1;
		WbStb      = 1'b1;
		WbWe       = write;
		WbAdr      = addr[`WB_ADDR_WIDTH-1:0];
		WbDatWrite = wdata;
		for (int i = 0; i < AckLimit && !ackSeen; i++)
		begin
			@(negedge Clk);
			ackSeen = WbAck;
		end
		if (!ackSeen)
			abortRun($sformatf("Bus access to address %0d was never acknowledged", addr));
		rdata = WbDatRead;
		// Hold the strobe through the acknowledge edge, then release the bus
		@(negedge Clk);
		WbCyc = 1'b0;
		WbStb = 1'b0;
		WbWe  = 1'b0;
		@(negedge Clk);
	endtask

	task automatic busWrite(input int addr, input logic [15:0] wdata);
		logic [15:0] unused;
		busTransfer(1'b1, addr, wdata, unused);
	endtask

	task automatic busRead(input int addr, output logic [15:0] rdata);
		busTransfer(1'b0, addr, 16'h0000, rdata);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [4:0] addFlags(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] sum;
		logic [4:0]  f;
		sum              = a + b;
		f                = '0;
		f[FLAG_CARRY]    = sum[16];
		f[FLAG_ZERO]     = (sum[15:0] == 16'h0000);
		f[FLAG_NEGATIVE] = sum[15];
		f[FLAG_OVERFLOW] = (a[15] == b[15]) && (sum[15] != a[15]);
		f[FLAG_LOWER]    = (a < b);
		return f;
	endfunction

	// Standard gfedcba glyphs, lit high, inverted for the active-low pins
	function automatic logic [6:0] hexGlyph(input logic [3:0] value);
		logic [6:0] lit;
		case (value)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	initial
	begin
		RESET      = 1'b1;
		WbCyc      = 1'b0;
		WbStb      = 1'b0;
		WbWe       = 1'b0;
		WbAdr      = '0;
		WbDatWrite = '0;
		cycleCount = 0;
		randomSeed = 32'h9dea_cb07;
		repeat (4) @(negedge Clk);
		RESET = 1'b0;

		// Everything reads zero out of reset
		for (int k = 0; k <= `ADDR_SEED_B; k++)
		begin
			busRead(k, readValue);
			checkValue($sformatf("reset read addr %0d", k), 0, readValue);
		end

		for (int run = 0; run < NumRuns; run++)
		begin
			model[0] = $random(randomSeed);
			model[1] = $random(randomSeed);
			for (int k = 2; k < `REG_COUNT; k++)
				model[k] = model[k-2] + model[k-1];
			expectedFlags = addFlags(model[`REG_COUNT-3], model[`REG_COUNT-2]);

			busWrite(`ADDR_SEED_A, model[0]);
			busWrite(`ADDR_SEED_B, model[1]);
			busWrite(`ADDR_CONTROL, 16'h0001);
			// Let r0 and r1 land before the seeds change under the running program
			repeat ((2 * `STEP_TICKS) / AccessCycles)
			begin
				busRead(`ADDR_CONTROL, readValue);
				checkValue($sformatf("run %0d busy after start", run), 1, readValue[0]);
			end
			// A restart would load these new seeds into r0 and r1
			busWrite(`ADDR_SEED_A, ~model[0]);
			busWrite(`ADDR_SEED_B, ~model[1]);
			busWrite(`ADDR_CONTROL, 16'h0001);
			do
				busRead(`ADDR_CONTROL, readValue);
			while (readValue[0]);

			for (int k = 0; k < `REG_COUNT; k++)
			begin
				busRead(k, readValue);
				checkValue($sformatf("run %0d r%0d", run, k), model[k], readValue);
			end
			busRead(`ADDR_CONTROL, readValue);
			checkValue($sformatf("run %0d control flags", run), {expectedFlags, 1'b0},
				readValue[5:0]);
			checkValue($sformatf("run %0d leds", run), expectedFlags[3:0], Led);

			seenDigits = '0;
			repeat (8 * `SCAN_TICKS)
			begin
				lowCount = 0;
				digit    = 0;
				for (int n = 0; n < 4; n++)
				begin
					if (!Enable[n])
					begin
						lowCount++;
						digit = n;
					end
				end
				checkValue($sformatf("run %0d single enable", run), 1, lowCount);
				seenDigits[digit] = 1'b1;
				checkValue($sformatf("run %0d digit %0d glyph", run, digit),
					hexGlyph(model[`REG_COUNT-1][digit*4 +: 4]), SevenSegment);
				@(negedge Clk);
			end
			checkValue($sformatf("run %0d digits scanned", run), 4'hF, seenDigits);
		end

		for (int k = `ADDR_SEED_B + 1; k < (1 << `WB_ADDR_WIDTH); k++)
		begin
			busRead(k, readValue);
			checkValue($sformatf("unmapped addr %0d", k), 0, readValue);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/datapath_pkg.sv
verilog/RegisterFile.sv
verilog/Alu.sv
verilog/ProgramSequencer.sv
verilog/HostBusPort.sv
verilog/SevenSegmentScanner.sv
verilog/FibonacciDatapathTop.sv
tests/FibonacciDatapathTb.sv
